//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := sync_conditioner_tb
FILELIST  := sync_conditioner_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/csync_gen.sv
// Composite sync generator with vsync serration
`timescale 1ns/1ps
`include "sync_conditioner_config.svh"

module csync_gen (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	output logic o_csync
);

	logic                   hs_d;
	logic [`SYNC_CNT_W-1:0] cnt;
	logic [`SYNC_CNT_W-1:0] hs_len;
	logic [`SYNC_CNT_W-1:0] lo_len;
	logic [`SYNC_CNT_W:0]   tail_sum;
	logic                   serr;
	logic                   csync_q;

	////////////////////
	// Line measurement
	////////////////////

	// One counter times both phases, restarted on each hsync edge
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_d   <= 1'b0;
			cnt    <= '0;
			hs_len <= '0;
			lo_len <= '0;
		end else begin
			hs_d <= i_hs;
			if (i_hs != hs_d) begin
				cnt <= '0;
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end
			if (i_hs & ~hs_d) begin
				lo_len <= cnt + 1'b1;
			end
			if (~i_hs & hs_d) begin
				hs_len <= cnt + 1'b1;
			end
		end
	end

	////////////////////
	// Serration
	////////////////////

	// Low phase position plus the hsync width, widened against overflow
	assign tail_sum = {1'b0, cnt} + {1'b0, hs_len} + 1'b1;

	// High from hsync start, low only for the last hsync width of the line
	assign serr = i_hs | hs_d | (tail_sum < {1'b0, lo_len});

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			csync_q <= 1'b0;
		end else begin
			csync_q <= i_vs ? serr : i_hs;
		end
	end

	assign o_csync = csync_q;

endmodule

//--- src/host_cmd_regs.sv
// Host command decoder: csync enable register, LED overtake and state, LED merge
`timescale 1ns/1ps
`include "sync_conditioner_config.svh"

module host_cmd_regs (
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  logic                 i_io_sel,
	input  logic                 i_io_strobe,
	input  sync_pkg::host_word_t i_io_din,
	input  sync_pkg::led_t       i_led_status,
	output logic                 o_csync_en,
	output sync_pkg::led_t       o_led
);

	////////////////////
	// Input sampling
	////////////////////

	logic                  sel_s;
	logic                  strobe_s;
	logic                  strobe_d;
	sync_pkg::host_word_t  din_s;
	logic                  strobe_rise;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sel_s    <= 1'b0;
			strobe_s <= 1'b0;
			strobe_d <= 1'b0;
		end else begin
			sel_s    <= i_io_sel;
			strobe_s <= i_io_strobe;
			strobe_d <= strobe_s;
		end
	end

	// Data word travels with the sampled strobe
	always_ff @(posedge clk_sys) begin
		din_s <= i_io_din;
	end

	// Rising edge of the strobe, one cycle after it shows on the port
	assign strobe_rise = strobe_s & ~strobe_d;

	////////////////////
	// Command tracking
	////////////////////

	logic                   has_cmd;
	logic [`SYNC_CMD_W-1:0] cmd;
	logic                   csync_en;
	sync_pkg::led_t         led_overtake;
	sync_pkg::led_t         led_state;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd      <= 1'b0;
			cmd          <= '0;
			csync_en     <= 1'b0;
			led_overtake <= '0;
			led_state    <= '0;
		end else if (!sel_s) begin
			// Deselect ends the transfer, next word is a command again
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (strobe_rise) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= din_s[`SYNC_CMD_W-1:0];
			end else begin
				case (cmd)
					`SYNC_CMD_CFG: begin
						// Only the csync enable of the config word is kept here
						csync_en <= din_s[`SYNC_CFG_CSYNC_BIT];
					end
					`SYNC_CMD_LED: begin
						// High byte is the overtake mask, low byte the state
						{led_overtake, led_state} <= din_s;
					end
					default: begin
						cmd <= cmd;
					end
				endcase
			end
		end
	end

	////////////////////
	// Outputs
	////////////////////

	assign o_csync_en = csync_en;

	// Overtaken bits show the host state, the rest show status
	assign o_led = (led_overtake & led_state) | (~led_overtake & i_led_status);

endmodule

//--- src/sync_conditioner_config.svh
// Width, command code, config bit and counter size macros for the sync conditioner
`ifndef SYNC_CONDITIONER_CONFIG_SVH
`define SYNC_CONDITIONER_CONFIG_SVH

//////////////////// Data widths
`define SYNC_PIX_W 24
`define SYNC_HOST_W 16
`define SYNC_LED_W 8

// Phase and line counters, covers line periods up to 65535 cycles
`define SYNC_CNT_W 16

// Sync channels, hsync and vsync
`define SYNC_N_CH 2

//////////////////// Host commands
`define SYNC_CMD_W 8
`define SYNC_CMD_CFG 8'h01
`define SYNC_CMD_LED 8'h25

// Csync enable inside the configuration word
`define SYNC_CFG_CSYNC_BIT 3

`endif

//--- src/sync_conditioner_top.sv
// Top level: host command decoder, per-channel polarity fixers and output stage
`timescale 1ns/1ps
`include "sync_conditioner_config.svh"

module sync_conditioner_top (
	input  logic                 clk_sys,
	input  logic                 resetd,

	// Host command port
	input  logic                 i_io_sel,
	input  logic                 i_io_strobe,
	input  sync_pkg::host_word_t i_io_din,
	input  sync_pkg::led_t       i_led_status,

	// Raw video in
	input  logic                 i_hs,
	input  logic                 i_vs,
	input  logic                 i_de,
	input  sync_pkg::pix_t       i_pix,

	// Conditioned video out
	output logic                 o_hs,
	output logic                 o_vs,
	output logic                 o_de,
	output sync_pkg::pix_t       o_pix,

	output sync_pkg::led_t       o_led
);

	logic [`SYNC_N_CH-1:0] sync_raw;
	logic [`SYNC_N_CH-1:0] sync_norm;
	logic                  csync_en;

	////////////////////
	// Host registers
	////////////////////

	host_cmd_regs host_cmd_regs_inst (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_sel     (i_io_sel),
		.i_io_strobe  (i_io_strobe),
		.i_io_din     (i_io_din),
		.i_led_status (i_led_status),
		.o_csync_en   (csync_en),
		.o_led        (o_led)
	);

	////////////////////
	// Polarity fix
	////////////////////

	assign sync_raw[sync_pkg::SYNC_CH_H] = i_hs;
	assign sync_raw[sync_pkg::SYNC_CH_V] = i_vs;

	// One fixer per sync line
	generate
		for (genvar ch = 0; ch < `SYNC_N_CH; ch++) begin : g_sync_fix
			sync_polarity_fix sync_polarity_fix_inst (
				.clk_sys (clk_sys),
				.resetd  (resetd),
				.i_sync  (sync_raw[ch]),
				.o_sync  (sync_norm[ch])
			);
		end
	endgenerate

	////////////////////
	// Output stage
	////////////////////

	sync_output_stage sync_output_stage_inst (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_csync_en (csync_en),
		.i_sync     (sync_norm),
		.i_de       (i_de),
		.i_pix      (i_pix),
		.o_hs       (o_hs),
		.o_vs       (o_vs),
		.o_de       (o_de),
		.o_pix      (o_pix)
	);

endmodule

//--- src/sync_output_stage.sv
// Output stage: hsync or composite sync select, registered video outputs
`timescale 1ns/1ps
`include "sync_conditioner_config.svh"

module sync_output_stage (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_csync_en,
	input  logic [`SYNC_N_CH-1:0]  i_sync,
	input  logic                   i_de,
	input  sync_pkg::pix_t         i_pix,
	output logic                   o_hs,
	output logic                   o_vs,
	output logic                   o_de,
	output sync_pkg::pix_t         o_pix
);

	logic           csync;
	logic           hs_bypass;
	logic           hs_q;
	logic           vs_q1;
	logic           vs_q2;
	logic           de_q1;
	logic           de_q2;
	sync_pkg::pix_t pix_q1;
	sync_pkg::pix_t pix_q2;

	csync_gen csync_gen_inst (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hs    (i_sync[sync_pkg::SYNC_CH_H]),
		.i_vs    (i_sync[sync_pkg::SYNC_CH_V]),
		.o_csync (csync)
	);

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_bypass <= 1'b0;
			hs_q      <= 1'b0;
			vs_q1     <= 1'b0;
			vs_q2     <= 1'b0;
			de_q1     <= 1'b0;
			de_q2     <= 1'b0;
			pix_q1    <= '0;
			pix_q2    <= '0;
		end else begin
			// Bypass gets the same one cycle that csync_gen costs
			hs_bypass <= i_sync[sync_pkg::SYNC_CH_H];
			hs_q      <= i_csync_en ? csync : hs_bypass;

			vs_q1  <= i_sync[sync_pkg::SYNC_CH_V];
			vs_q2  <= vs_q1;
			de_q1  <= i_de;
			de_q2  <= de_q1;
			pix_q1 <= i_pix;
			pix_q2 <= pix_q1;
		end
	end

	assign o_hs  = hs_q;
	assign o_vs  = vs_q2;
	assign o_de  = de_q2;
	assign o_pix = pix_q2;

endmodule

//--- src/sync_pkg.sv
// Shared types: pixel word, host word, LED byte and sync channel index
`include "sync_conditioner_config.svh"

package sync_pkg;

	//////////////////// Video payload

	// Packed RGB, red in the top byte
	typedef logic [`SYNC_PIX_W-1:0] pix_t;

	//////////////////// Host port

	// One strobed command or data word
	typedef logic [`SYNC_HOST_W-1:0] host_word_t;

	// Main board LEDs
	typedef logic [`SYNC_LED_W-1:0] led_t;

	//////////////////// Sync channels

	// Bit position of each sync line in the channel vectors
	typedef enum logic [0:0] {
		SYNC_CH_H = 1'b0,
		SYNC_CH_V = 1'b1
	} sync_ch_e;

endpackage

//--- src/sync_polarity_fix.sv
// Sync polarity normalizer, makes one sync line an active high pulse on its shorter phase
`timescale 1ns/1ps
`include "sync_conditioner_config.svh"

module sync_polarity_fix (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                   sync_s1;
	logic                   sync_s2;
	logic                   edge_seen;
	logic [`SYNC_CNT_W-1:0] phase_cnt;
	logic [`SYNC_CNT_W-1:0] high_len;
	logic [`SYNC_CNT_W-1:0] low_len;
	logic                   pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_s1   <= 1'b0;
			sync_s2   <= 1'b0;
			edge_seen <= 1'b0;
			phase_cnt <= '0;
			high_len  <= '0;
			low_len   <= '0;
			pol       <= 1'b0;
		end else begin
			sync_s1   <= i_sync;
			sync_s2   <= sync_s1;
			edge_seen <= sync_s1 ^ sync_s2;

			// Phase length counter, restarts on every edge, holds at max
			if (sync_s1 ^ sync_s2) begin
				phase_cnt <= '0;
			end else if (phase_cnt != '1) begin
				phase_cnt <= phase_cnt + 1'b1;
			end

			// Rising edge closes a low phase, falling edge a high one
			if (sync_s1 & ~sync_s2) begin
				low_len <= phase_cnt;
			end
			if (~sync_s1 & sync_s2) begin
				high_len <= phase_cnt;
			end

			// Longer high phase means the active part is low
			if (edge_seen) begin
				pol <= high_len > low_len;
			end
		end
	end

	// No added latency on the sync itself
	assign o_sync = i_sync ^ pol;

endmodule

//--- sync_conditioner_top.f
+incdir+src
src/sync_pkg.sv
src/host_cmd_regs.sv
src/sync_polarity_fix.sv
src/csync_gen.sv
src/sync_output_stage.sv
src/sync_conditioner_top.sv
verif/sync_conditioner_chk.sv
verif/sync_conditioner_tb.sv

//--- verif/sync_conditioner_chk.sv
// Bound assertions: reset values, DE delay and LED pass-through
`timescale 1ns/1ps

module sync_conditioner_chk (
	input logic           clk_sys,
	input logic           resetd,
	input logic           i_de,
	input sync_pkg::led_t i_led_status,
	input sync_pkg::led_t i_overtake,
	input logic           i_out_hs,
	input logic           i_out_vs,
	input logic           i_out_de,
	input sync_pkg::pix_t i_out_pix,
	input sync_pkg::led_t i_out_led
);

	int unsigned fail_count = 0;

	// Reset clears the video outputs
	reset_outputs_low: assert property (@(posedge clk_sys)
		resetd |=> (!i_out_hs && !i_out_vs && !i_out_de && i_out_pix == '0))
	else begin
		$error("video outputs not low after a reset cycle");
		fail_count++;
	end

	de_two_cycle_delay: assert property (@(posedge clk_sys) disable iff (resetd)
		!$past(resetd) && !$past(resetd, 2) |-> i_out_de == $past(i_de, 2))
	else begin
		$error("o_de is not i_de delayed by two cycles");
		fail_count++;
	end

	// No overtaken bit, status shows through
	led_pass_through: assert property (@(posedge clk_sys) disable iff (resetd)
		i_overtake == '0 |-> i_out_led == i_led_status)
	else begin
		$error("o_led differs from i_led_status with no overtake");
		fail_count++;
	end

endmodule

//--- verif/sync_conditioner_tb.sv
// Testbench: clock, reset, scenario table, reference model, checks and closing report
`timescale 1ns/1ps
`include "sync_conditioner_config.svh"

module sync_conditioner_tb;

	localparam int N_ROWS  = 4;
	localparam int N_LINES = 10;
	localparam int SETTLE  = 2;
	localparam int CHECKED = 2;
	localparam int MARGIN  = 2000;

	typedef struct {
		int             hs_act;
		int             hw;
		int             lp;
		int             vs_act;
		int             vl;
		int             csync;
		logic [15:0]    led_word;
		sync_pkg::led_t led_status;
		sync_pkg::led_t led_exp;
	} row_t;

	// Expected outputs for one input cycle
	typedef struct packed {
		logic           sync_chk;
		logic           hs;
		logic           vs;
		logic           de;
		sync_pkg::pix_t pix;
	} exp_t;

	// hs active level, hs width, line period, vs active level, vs lines,
	// csync enable, LED command word, LED status, expected LED byte
	row_t rows [N_ROWS] = '{
		'{0, 4, 32, 0, 2, 0, 16'hF0A5, 8'h3C, 8'hAC},
		'{1, 6, 40, 1, 3, 0, 16'h0FFF, 8'h00, 8'h0F},
		'{0, 5, 36, 1, 3, 1, 16'h3300, 8'hFF, 8'hCC},
		'{1, 3, 28, 0, 2, 1, 16'h0000, 8'h5A, 8'h5A}
	};

	logic                 clk_sys;
	logic                 resetd;
	logic                 i_io_sel;
	logic                 i_io_strobe;
	sync_pkg::host_word_t i_io_din;
	sync_pkg::led_t       i_led_status;
	logic                 i_hs;
	logic                 i_vs;
	logic                 i_de;
	sync_pkg::pix_t       i_pix;
	logic                 o_hs;
	logic                 o_vs;
	logic                 o_de;
	sync_pkg::pix_t       o_pix;
	sync_pkg::led_t       o_led;

	logic [31:0] lcg_state;
	exp_t        exp_q [$];
	int          checks = 0;
	int          errors = 0;
	int          chk_fails = 0;
	int          cycles = 0;
	int          cycle_limit = 0;

	sync_conditioner_top sync_conditioner_top_inst (.*);

	bind sync_conditioner_top sync_conditioner_chk sync_conditioner_chk_inst (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_de         (i_de),
		.i_led_status (i_led_status),
		.i_overtake   (host_cmd_regs_inst.led_overtake),
		.i_out_hs     (o_hs),
		.i_out_vs     (o_vs),
		.i_out_de     (o_de),
		.i_out_pix    (o_pix),
		.i_out_led    (o_led)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout: test did not end within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Streamed frames of every row plus room for the host commands
	function automatic int run_cycles();
		int total;
		total = 0;
		for (int r = 0; r < N_ROWS; r++) begin
			total += (SETTLE + CHECKED) * N_LINES * rows[r].lp;
		end
		return total + MARGIN;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("mismatch at %0d ns: %s expected %0h, got %0h", $time, name, want, got);
		end
	endtask

	task automatic send_word(input logic [15:0] word);
		@(posedge clk_sys);
		i_io_din    <= word;
		i_io_strobe <= 1'b1;
		repeat (2) @(posedge clk_sys);
		i_io_strobe <= 1'b0;
		@(posedge clk_sys);
	endtask

	// One select window: command word, data word, then deselect
	task automatic send_cmd(input logic [15:0] cmd, input logic [15:0] data);
		@(posedge clk_sys);
		i_io_sel <= 1'b1;
		send_word(cmd);
		send_word(data);
		repeat (2) @(posedge clk_sys);
		i_io_sel <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	// Outputs lag the inputs by two cycles
	task automatic drive_cycle(input logic hs, input logic vs, input exp_t now);
		exp_t past;
		@(posedge clk_sys);
		i_hs  <= hs;
		i_vs  <= vs;
		i_de  <= now.de;
		i_pix <= now.pix;
		exp_q.push_back(now);
		@(negedge clk_sys);
		if (exp_q.size() > 2) begin
			past = exp_q.pop_front();
			compare_value("o_de", 32'(o_de), 32'(past.de));
			compare_value("o_pix", 32'(o_pix), 32'(past.pix));
			if (past.sync_chk) begin
				compare_value("o_hs", 32'(o_hs), 32'(past.hs));
				compare_value("o_vs", 32'(o_vs), 32'(past.vs));
			end
		end
	endtask

	task automatic run_frames(input int r);
		exp_t now;
		logic act_h;
		logic in_vs;
		for (int f = 0; f < SETTLE + CHECKED; f++) begin
			for (int ln = 0; ln < N_LINES; ln++) begin
				for (int pos = 0; pos < rows[r].lp; pos++) begin
					act_h = pos < rows[r].hw;
					in_vs = ln < rows[r].vl;
					lcg_state = lcg_next(lcg_state);
					now.sync_chk = f >= SETTLE;
					now.vs = in_vs;
					// Serrated lines: high for period minus width, low for width
					if (rows[r].csync != 0 && in_vs) begin
						now.hs = pos < rows[r].lp - rows[r].hw;
					end else begin
						now.hs = act_h;
					end
					now.de  = !in_vs && pos >= rows[r].hw + 2 && pos < rows[r].lp - 2;
					now.pix = lcg_state[31:8];
					drive_cycle(act_h ^ (rows[r].hs_act == 0), in_vs ^ (rows[r].vs_act == 0), now);
				end
			end
		end
	endtask

	initial begin
		lcg_state    = 32'h9022878f;
		resetd       = 1'b1;
		i_io_sel     = 1'b0;
		i_io_strobe  = 1'b0;
		i_io_din     = '0;
		i_led_status = 8'h69;
		i_hs         = 1'b0;
		i_vs         = 1'b0;
		i_de         = 1'b0;
		i_pix        = '0;
		repeat (2) @(posedge clk_sys);
		cycle_limit = run_cycles();
		resetd <= 1'b0;
		@(negedge clk_sys);
		compare_value("o_hs", 32'(o_hs), 32'd0);
		compare_value("o_vs", 32'(o_vs), 32'd0);
		compare_value("o_de", 32'(o_de), 32'd0);
		compare_value("o_led", 32'(o_led), 32'(i_led_status));
		for (int r = 0; r < N_ROWS; r++) begin
			// Sync lines idle at their inactive level during the commands
			@(posedge clk_sys);
			i_hs         <= rows[r].hs_act == 0;
			i_vs         <= rows[r].vs_act == 0;
			i_de         <= 1'b0;
			i_led_status <= rows[r].led_status;
			exp_q.delete();
			send_cmd({8'h00, `SYNC_CMD_CFG}, 16'(rows[r].csync) << `SYNC_CFG_CSYNC_BIT);
			send_cmd({8'h00, `SYNC_CMD_LED}, rows[r].led_word);
			@(negedge clk_sys);
			compare_value("o_led", 32'(o_led), 32'(rows[r].led_exp));
			// First word of a new select is an unknown command
			send_cmd(16'hFF00, 16'hFFFF);
			@(negedge clk_sys);
			compare_value("o_led", 32'(o_led), 32'(rows[r].led_exp));
			run_frames(r);
		end
		chk_fails = sync_conditioner_top_inst.sync_conditioner_chk_inst.fail_count;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, chk_fails);
		if (errors == 0 && chk_fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
